// File: source/div_pkg.sv
// Shared definitions for the RV64M divide unit.
// Data word and opcode widths, divide opcodes, iteration counter
// and the divider state encoding.

package div_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [7:0]      opcode_t;
    typedef logic [6:0]      count_t;   // Holds 0 to 64.

    // Divide opcodes as carried on the opcode field.
    localparam opcode_t INST_DIV   = 8'h50;
    localparam opcode_t INST_DIVU  = 8'h51;
    localparam opcode_t INST_REM   = 8'h52;
    localparam opcode_t INST_REMU  = 8'h53;
    localparam opcode_t INST_DIVW  = 8'h54;
    localparam opcode_t INST_DIVUW = 8'h55;
    localparam opcode_t INST_REMW  = 8'h56;
    localparam opcode_t INST_REMUW = 8'h57;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'b00,
        DIV_ITER = 2'b01,
        DIV_DONE = 2'b10
    } div_state_e;

endpackage

// File: source/div_op_decode.sv
// Input side of the divide unit.
// Opcode decode, word narrowing, operand magnitudes, result sign
// flags and the accept strobe.

`timescale 1ns/1ps

module div_op_decode (
    input  div_pkg::opcode_t inst_opcode,
    input  div_pkg::xlen_t   dividend,
    input  div_pkg::xlen_t   divisor,
    input  logic             div_ready,
    input  logic             div_busy,
    output logic             accept,
    output div_pkg::xlen_t   abs_dividend,
    output div_pkg::xlen_t   abs_divisor,
    output div_pkg::xlen_t   raw_dividend,
    output logic             neg_quot,
    output logic             neg_rem,
    output logic             div_zero,
    output logic             op_rem,
    output logic             op_word
);
    import div_pkg::*;

    logic  is_div_op;
    logic  op_signed;
    xlen_t nar_dividend;
    xlen_t nar_divisor;

    assign op_signed = (inst_opcode == INST_DIV)  || (inst_opcode == INST_REM) ||
                       (inst_opcode == INST_DIVW) || (inst_opcode == INST_REMW);
    assign op_word   = (inst_opcode == INST_DIVW) || (inst_opcode == INST_DIVUW) ||
                       (inst_opcode == INST_REMW) || (inst_opcode == INST_REMUW);
    assign op_rem    = (inst_opcode == INST_REM)  || (inst_opcode == INST_REMU) ||
                       (inst_opcode == INST_REMW) || (inst_opcode == INST_REMUW);
    assign is_div_op = op_signed || op_word || op_rem || (inst_opcode == INST_DIVU);

    assign accept = div_ready && !div_busy && is_div_op;

    // W forms keep bit 31 as the sign of the whole word.
    always_comb begin
        nar_dividend = dividend;
        nar_divisor  = divisor;
        if (op_word) begin
            nar_dividend = {{32{op_signed & dividend[31]}}, dividend[31:0]};
            nar_divisor  = {{32{op_signed & divisor[31]}}, divisor[31:0]};
        end
    end

    // Most negative value maps onto 2^63 as an unsigned magnitude.
    assign abs_dividend = (op_signed && nar_dividend[XLEN-1]) ? -nar_dividend : nar_dividend;
    assign abs_divisor  = (op_signed && nar_divisor[XLEN-1])  ? -nar_divisor  : nar_divisor;

    assign neg_quot     = op_signed && (nar_dividend[XLEN-1] ^ nar_divisor[XLEN-1]);
    assign neg_rem      = op_signed && nar_dividend[XLEN-1];   // Remainder follows dividend.
    assign div_zero     = (nar_divisor == '0);
    assign raw_dividend = nar_dividend;

endmodule

// File: source/div_iter_core.sv
// Processing part of the divide unit.
// Restoring shift-subtract divider producing one quotient bit per
// clock, with its control FSM and busy and done flags.

`timescale 1ns/1ps

module div_iter_core (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           accept,
    input  div_pkg::xlen_t abs_dividend,
    input  div_pkg::xlen_t abs_divisor,
    output logic           div_busy,
    output logic           core_done,
    output div_pkg::xlen_t quotient,
    output div_pkg::xlen_t remainder
);
    import div_pkg::*;

    div_state_e state_q;
    div_state_e state_d;
    count_t     count_q;
    xlen_t      quo_q;
    xlen_t      rem_q;
    xlen_t      dsr_q;

    logic [XLEN:0] shifted;
    logic [XLEN:0] diff;
    logic          fits;
    logic          last_iter;

    // One restoring step on the current partial remainder.
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dsr_q};
    assign fits    = (shifted >= {1'b0, dsr_q});

    assign last_iter = (count_q == count_t'(XLEN - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            DIV_IDLE: begin
                if (accept) begin
                    state_d = DIV_ITER;
                end
            end
            DIV_ITER: begin
                if (last_iter) begin
                    state_d = DIV_DONE;
                end
            end
            DIV_DONE: begin
                state_d = DIV_IDLE;     // Result is taken this cycle.
            end
            default: begin
                state_d = DIV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= DIV_IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == DIV_IDLE) begin
                count_q <= '0;
            end else if (state_q == DIV_ITER) begin
                count_q <= count_q + count_t'(1);
            end
        end
    end

    // Datapath.
    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE) begin
            if (accept) begin
                quo_q <= abs_dividend;  // Dividend bits shift out as quotient bits enter.
                rem_q <= '0;
                dsr_q <= abs_divisor;
            end
        end else if (state_q == DIV_ITER) begin
            if (fits) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    assign div_busy  = (state_q != DIV_IDLE);
    assign core_done = (state_q == DIV_DONE);
    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

// File: source/div_result_fix.sv
// Output side of the divide unit.
// Latches the operation flags, applies result signs and the
// divide-by-zero rule, selects and registers the result.

`timescale 1ns/1ps

module div_result_fix (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           accept,
    input  logic           neg_quot,
    input  logic           neg_rem,
    input  logic           div_zero,
    input  logic           op_rem,
    input  logic           op_word,
    input  div_pkg::xlen_t raw_dividend,
    input  logic           core_done,
    input  div_pkg::xlen_t quotient,
    input  div_pkg::xlen_t remainder,
    output div_pkg::xlen_t div_rem_data,
    output logic           div_finish
);
    import div_pkg::*;

    logic  neg_quot_q;
    logic  neg_rem_q;
    logic  div_zero_q;
    logic  op_rem_q;
    logic  op_word_q;
    xlen_t raw_dividend_q;

    xlen_t quot_fix;
    xlen_t rem_fix;
    xlen_t sel;
    xlen_t result;

    always_ff @(posedge clk) begin
        if (accept) begin
            neg_quot_q     <= neg_quot;
            neg_rem_q      <= neg_rem;
            div_zero_q     <= div_zero;
            op_rem_q       <= op_rem;
            op_word_q      <= op_word;
            raw_dividend_q <= raw_dividend;
        end
    end

    // Overflow case falls out of the negation. 2^63 negates to itself.
    assign quot_fix = div_zero_q ? '1 : (neg_quot_q ? -quotient : quotient);
    assign rem_fix  = div_zero_q ? raw_dividend_q : (neg_rem_q ? -remainder : remainder);
    assign sel      = op_rem_q ? rem_fix : quot_fix;
    assign result   = op_word_q ? {{32{sel[31]}}, sel[31:0]} : sel;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_rem_data <= '0;
            div_finish   <= 1'b0;
        end else begin
            div_finish <= core_done;
            if (core_done) begin
                div_rem_data <= result;     // Held until the next finish.
            end
        end
    end

endmodule

// File: source/div_unit.sv
// Top level of the RV64M iterative divide unit.
// Connects the opcode decoder, the restoring divider core and the
// result correction stage.

`timescale 1ns/1ps

module div_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  div_pkg::xlen_t   dividend,
    input  div_pkg::xlen_t   divisor,
    input  div_pkg::opcode_t inst_opcode,
    input  logic             div_ready,
    output logic             div_busy,
    output div_pkg::xlen_t   div_rem_data,
    output logic             div_finish
);
    import div_pkg::*;

    logic  accept;
    logic  neg_quot;
    logic  neg_rem;
    logic  div_zero;
    logic  op_rem;
    logic  op_word;
    logic  core_done;
    xlen_t abs_dividend;
    xlen_t abs_divisor;
    xlen_t raw_dividend;
    xlen_t quotient;
    xlen_t remainder;

    div_op_decode u_decode (
        .inst_opcode  (inst_opcode),
        .dividend     (dividend),
        .divisor      (divisor),
        .div_ready    (div_ready),
        .div_busy     (div_busy),
        .accept       (accept),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .raw_dividend (raw_dividend),
        .neg_quot     (neg_quot),
        .neg_rem      (neg_rem),
        .div_zero     (div_zero),
        .op_rem       (op_rem),
        .op_word      (op_word)
    );

    div_iter_core u_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept       (accept),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .div_busy     (div_busy),
        .core_done    (core_done),
        .quotient     (quotient),
        .remainder    (remainder)
    );

    div_result_fix u_fix (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept       (accept),
        .neg_quot     (neg_quot),
        .neg_rem      (neg_rem),
        .div_zero     (div_zero),
        .op_rem       (op_rem),
        .op_word      (op_word),
        .raw_dividend (raw_dividend),
        .core_done    (core_done),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_rem_data (div_rem_data),
        .div_finish   (div_finish)
    );

endmodule

// File: sim/div_unit_assertions.sv
// Concurrent assertions on the divide unit strobes.
// Bound into the div_unit top level.

`timescale 1ns/1ps

module div_unit_assertions (
    input logic clk,
    input logic rst_n,
    input logic div_busy,
    input logic div_finish
);

    int fail_count = 0;     // Read back by the testbench.

    // Finish is a single-cycle pulse.
    a_finish_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        div_finish |=> !div_finish)
        else begin
            $error("div_finish high for two consecutive cycles");
            fail_count++;
        end

    a_busy_before_finish: assert property (@(posedge clk) disable iff (!rst_n)
        div_finish |-> $past(div_busy))
        else begin
            $error("div_finish without div_busy in the cycle before");
            fail_count++;
        end

    a_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!div_busy && !div_finish))
        else begin
            $error("div_busy or div_finish high right after reset");
            fail_count++;
        end

endmodule

bind div_unit div_unit_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .div_busy   (div_busy),
    .div_finish (div_finish)
);

// File: sim/div_unit_tb.sv
// Testbench for the RV64M divide unit.
// Seeded random and corner-case operations checked against a
// reference model, ignored strobes and fixed latency.

`timescale 1ns/1ps

module div_unit_tb;
    import div_pkg::*;

    logic    clk = 1'b0;
    logic    rst_n;
    xlen_t   dividend;
    xlen_t   divisor;
    opcode_t inst_opcode;
    logic    div_ready;
    logic    div_busy;
    xlen_t   div_rem_data;
    logic    div_finish;

    opcode_t ops [8] = '{INST_DIV, INST_DIVU, INST_REM, INST_REMU,
                         INST_DIVW, INST_DIVUW, INST_REMW, INST_REMUW};
    int      errors = 0;
    int      checks = 0;
    int      tests = 0;
    int      test_errors;
    int      test_checks;
    int      bad;
    int      cycles;
    xlen_t   a;
    xlen_t   b;
    xlen_t   exp_val;

    div_unit uut (.*);

    always #10 clk = ~clk;

    // RISC-V divide rules applied directly to the operands.
    task automatic model_result(input opcode_t op, input xlen_t x, input xlen_t y,
                                output xlen_t res);
        logic  sgn;
        logic  word;
        logic  rem;
        xlen_t q;
        xlen_t r;
        sgn  = (op == INST_DIV) || (op == INST_REM) || (op == INST_DIVW) || (op == INST_REMW);
        word = (op == INST_DIVW) || (op == INST_DIVUW) || (op == INST_REMW) || (op == INST_REMUW);
        rem  = (op == INST_REM) || (op == INST_REMU) || (op == INST_REMW) || (op == INST_REMUW);
        if (word) begin
            x = sgn ? {{32{x[31]}}, x[31:0]} : {32'h0, x[31:0]};
            y = sgn ? {{32{y[31]}}, y[31:0]} : {32'h0, y[31:0]};
        end
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (sgn && x == {1'b1, 63'h0} && y == '1) begin
            q = x;   // Signed overflow.
            r = '0;
        end else if (sgn) begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end else begin
            q = x / y;
            r = x % y;
        end
        res = rem ? r : q;
        if (word) res = {{32{res[31]}}, res[31:0]};
    endtask

    task automatic abort_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic start_op(input opcode_t op, input xlen_t x, input xlen_t y);
        int n;
        n = 0;
        while (div_busy) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 200) abort_run("Timeout waiting for div_busy to fall");
        end
        inst_opcode = op;
        dividend    = x;
        divisor     = y;
        div_ready   = 1'b1;
        @(posedge clk);
        #1;
        div_ready = 1'b0;
        dividend  = {$urandom, $urandom};   // Scramble after capture.
        divisor   = {$urandom, $urandom};
    endtask

    task automatic wait_finish(output int n);
        n = 0;
        while (!div_finish) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 200) abort_run("Timeout waiting for div_finish");
        end
    endtask

    task automatic run_op(input opcode_t op, input xlen_t x, input xlen_t y);
        xlen_t exp_res;
        int    n;
        model_result(op, x, y, exp_res);
        start_op(op, x, y);
        checks++;
        if (div_busy !== 1'b1) begin
            errors++;
            $display("Error at %0t: div_busy expected 1 actual %b", $time, div_busy);
        end
        wait_finish(n);
        checks++;
        if (div_rem_data !== exp_res) begin
            errors++;
            $display("Error at %0t: div_rem_data expected %h actual %h (op %h, %h / %h)",
                     $time, exp_res, div_rem_data, op, x, y);
        end
        checks++;
        if (n != 65) begin
            errors++;
            $display("div_finish came %0d cycles after the strobe edge instead of 65", n);
        end
    endtask

    task automatic begin_test();
        test_errors = errors;
        test_checks = checks;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - test_checks, errors - test_errors);
    endtask

    initial begin
        void'($urandom(32'h7385_6ae3));
        rst_n       = 1'b0;
        dividend    = '0;
        divisor     = '0;
        inst_opcode = '0;
        div_ready   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test();
        checks += 3;
        if (div_busy !== 1'b0) begin
            errors++;
            $display("Error at %0t: div_busy expected 0 actual %b", $time, div_busy);
        end
        if (div_finish !== 1'b0) begin
            errors++;
            $display("Error at %0t: div_finish expected 0 actual %b", $time, div_finish);
        end
        if (div_rem_data !== '0) begin
            errors++;
            $display("Error at %0t: div_rem_data expected 0 actual %h", $time, div_rem_data);
        end
        end_test("reset state");

        begin_test();
        for (int i = 0; i < 200; i++) begin
            a = {$urandom, $urandom};
            b = {$urandom, $urandom} >> ($urandom % 64);
            run_op(ops[$urandom % 4], a, b);
        end
        end_test("double-word random");

        begin_test();
        for (int i = 0; i < 200; i++) begin
            a = {$urandom, $urandom};
            b = {$urandom, 32'($urandom >> ($urandom % 32))};   // Upper half is noise.
            run_op(ops[4 + $urandom % 4], a, b);
        end
        end_test("word random");

        begin_test();
        for (int i = 0; i < 8; i++) begin
            run_op(ops[i], {$urandom, $urandom}, {(i >= 4) ? $urandom : 32'h0, 32'h0});
            run_op(ops[i], {$urandom, $urandom}, 64'd1);
            a = {$urandom, $urandom} | 64'd1;
            run_op(ops[i], a, a);
        end
        run_op(INST_DIV, 64'h8000_0000_0000_0000, '1);
        run_op(INST_REM, 64'h8000_0000_0000_0000, '1);
        run_op(INST_DIVW, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff});
        run_op(INST_REMW, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff});
        end_test("corner cases");

        begin_test();
        a = {$urandom, $urandom};
        b = {32'h0, $urandom};
        model_result(INST_DIVU, a, b, exp_val);
        start_op(INST_DIVU, a, b);
        repeat (10) begin
            @(posedge clk);
            #1;
        end
        inst_opcode = INST_REM;     // Strobe while busy.
        div_ready   = 1'b1;
        @(posedge clk);
        #1;
        div_ready = 1'b0;
        wait_finish(cycles);
        checks++;
        if (div_rem_data !== exp_val) begin
            errors++;
            $display("Error at %0t: div_rem_data expected %h actual %h",
                     $time, exp_val, div_rem_data);
        end
        // Strobe sat 11 edges into the 65-cycle run.
        checks++;
        if (cycles != 54) begin
            errors++;
            $display("div_finish came %0d cycles after the busy strobe instead of 54", cycles);
        end
        inst_opcode = 8'h58;        // Not a divide opcode.
        div_ready   = 1'b1;
        @(posedge clk);
        #1;
        div_ready = 1'b0;
        bad = 0;
        for (int i = 0; i < 100; i++) begin
            if (div_busy || div_finish) bad++;
            @(posedge clk);
            #1;
        end
        checks++;
        if (bad != 0) begin
            errors++;
            $display("An ignored strobe started an operation or gave an extra div_finish");
        end
        end_test("ignored strobes");

        begin_test();
        run_op(INST_DIVU, {$urandom, $urandom}, {32'h0, $urandom});
        run_op(INST_REM, {$urandom, $urandom}, {$urandom, $urandom});   // Back to back.
        run_op(INST_DIVW, {$urandom, $urandom}, {$urandom, $urandom});
        end_test("latency and back-to-back");

        if (uut.u_assertions.fail_count != 0) begin
            errors += uut.u_assertions.fail_count;
            $display("%0d assertion failures in the bound checker",
                     uut.u_assertions.fail_count);
        end

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
source/div_pkg.sv
source/div_op_decode.sv
source/div_iter_core.sv
source/div_result_fix.sv
source/div_unit.sv
sim/div_unit_assertions.sv
sim/div_unit_tb.sv

// File: Bender.yml
package:
  name: div_unit

sources:
  - source/div_pkg.sv
  - source/div_op_decode.sv
  - source/div_iter_core.sv
  - source/div_result_fix.sv
  - source/div_unit.sv
  - target: simulation
    files:
      - sim/div_unit_assertions.sv
      - sim/div_unit_tb.sv
